// ==== rtl/cpu_cfg.svh ====
// Build-time sizes only. The memory depth must equal 2**CPU_ADDR_W and TRACE_DEPTH a power of two.
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath, register and instruction width
`define CPU_DATA_W 16

// each memory holds this many words
`define CPU_MEM_DEPTH 64

// word address into either memory
`define CPU_ADDR_W 6

// architectural registers including r0
`define CPU_NREGS 8

// cycle counter width, wraps silently
`define TRACE_STAMP_W 16

// retirement records buffered before the core freezes
`define TRACE_DEPTH 8

`endif

// ==== rtl/isa_pkg.sv ====
// Opcodes 10 to 15 are not defined and pass through the core as no-ops.
package isa_pkg;

    // major opcode in bits 15:12
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,
        OP_LW   = 4'd6,
        OP_SW   = 4'd7,
        OP_BEQZ = 4'd8,
        OP_HALT = 4'd9
    } opcode_e;

    // one of eight registers
    typedef logic [2:0] reg_idx_t;

    // one instruction word, two views of the low 12 bits
    // store takes its data from rd, branch tests rd
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            reg_idx_t   rd;
            reg_idx_t   rs1;
            reg_idx_t   rs2;
            logic [2:0] unused;
        } r_form;
        struct packed {
            opcode_e           opcode;
            reg_idx_t          rd;
            reg_idx_t          rs1;
            logic signed [5:0] imm;
        } i_form;
    } instr_u;

endpackage

// ==== rtl/trace_pkg.sv ====
// Stamps wrap after 2**TRACE_STAMP_W cycles and seq wraps after 65536 retirements.
`include "cpu_cfg.svh"

package trace_pkg;

    // retirement order number, 0 for the first retired instruction
    typedef logic [15:0] trace_seq_t;

    // value of the free-running cycle counter
    typedef logic [`TRACE_STAMP_W-1:0] stamp_t;

endpackage

// ==== rtl/core_mem.sv ====
// Word memory with no reset; contents are undefined until written.
`include "cpu_cfg.svh"

module core_mem (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`CPU_ADDR_W-1:0] waddr,
    input  logic [`CPU_DATA_W-1:0] wdata,
    input  logic [`CPU_ADDR_W-1:0] raddr,
    output logic [`CPU_DATA_W-1:0] rdata
);

    logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

    // clocked write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read is combinational, data back in the same cycle
    assign rdata = mem[raddr];

endmodule

// ==== rtl/core_regfile.sv ====
// Register 0 always reads zero; a read of the register being written returns the new value.
`include "cpu_cfg.svh"

module core_regfile import isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  reg_idx_t               ra1,
    input  reg_idx_t               ra2,
    output logic [`CPU_DATA_W-1:0] rd1,
    output logic [`CPU_DATA_W-1:0] rd2,
    input  logic                   we,
    input  reg_idx_t               wa,
    input  logic [`CPU_DATA_W-1:0] wd
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            // writes to r0 dropped
            regs[wa] <= wd;
        end
    end

    // write-through covers the write-back to decode distance
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== rtl/core_alu.sv ====
// The zero flag tests operand a; the core routes the branch register there.
`include "cpu_cfg.svh"

module core_alu import isa_pkg::*; (
    input  opcode_e                op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    output logic [`CPU_DATA_W-1:0] y,
    output logic                   zero
);

    always_comb begin
        case (op)
            OP_ADD:  y = a + b;
            OP_SUB:  y = a - b;
            OP_AND:  y = a & b;
            OP_OR:   y = a | b;
            OP_XOR:  y = a ^ b;
            // immediate add and the load/store address
            OP_ADDI,
            OP_LW,
            OP_SW:   y = a + b;
            // branch, halt and undefined codes
            default: y = '0;
        endcase
    end

    // beqz condition
    assign zero = (a == '0);

endmodule

// ==== rtl/pipe_core.sv ====
// In-order five-stage core with word addressing only; branches resolve in execute.
`include "cpu_cfg.svh"

module pipe_core import isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   freeze,
    output logic [`CPU_ADDR_W-1:0] imem_addr,
    input  logic [`CPU_DATA_W-1:0] imem_data,
    output logic [`CPU_ADDR_W-1:0] dmem_addr,
    output logic                   dmem_we,
    output logic [`CPU_DATA_W-1:0] dmem_wdata,
    input  logic [`CPU_DATA_W-1:0] dmem_rdata,
    output logic                   if_fire,
    output logic                   advance,
    output logic                   stall_id,
    output logic                   flush_br,
    output logic                   wb_valid,
    output logic [`CPU_ADDR_W-1:0] wb_pc,
    output instr_u                 wb_instr,
    output reg_idx_t               wb_rd,
    output logic                   wb_we,
    output logic [`CPU_DATA_W-1:0] wb_data,
    output logic                   halted
);

    // stage registers, named by the boundary they sit on
    logic [`CPU_ADDR_W-1:0] pc, fd_pc, de_pc, em_pc, mw_pc;
    logic                   fd_valid, de_valid, em_valid, mw_valid, halt_stop;
    instr_u                 fd_instr, de_instr, em_instr, mw_instr;
    logic [`CPU_DATA_W-1:0] de_v1, de_v2, em_alu, em_sd, mw_data;
    reg_idx_t               de_s2;

    opcode_e                id_op, ex_op, mem_op, wb_op;
    reg_idx_t               id_ra2, ld_rd;
    logic                   id_use1, id_use2, id_halt, alu_zero;
    logic [`CPU_DATA_W-1:0] rf_rd1, rf_rd2, ex_f1, ex_f2, ex_imm, alu_a, alu_b, alu_y;
    logic [`CPU_ADDR_W-1:0] br_target;

    // ops that write rd
    function automatic logic writes_rd(opcode_e op);
        return op inside {[OP_ADD:OP_LW]};
    endfunction

    // newest producer wins, memory stage before write-back
    function automatic logic [`CPU_DATA_W-1:0] fwd(reg_idx_t r, logic [`CPU_DATA_W-1:0] v);
        if (r != '0 && em_valid && writes_rd(mem_op) && em_instr.r_form.rd == r) begin
            return em_alu;
        end
        if (r != '0 && mw_valid && writes_rd(wb_op) && mw_instr.r_form.rd == r) begin
            return mw_data;
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // fetch control and decode
    ////////////////////////////////////////////////////////////

    assign advance   = !freeze;
    assign imem_addr = pc;
    // the slot behind a decoded halt is never fetched
    assign if_fire   = advance && run && !halt_stop && !id_halt && !stall_id && !flush_br;

    assign id_op   = fd_instr.r_form.opcode;
    assign id_halt = fd_valid && id_op == OP_HALT;
    // port 2 reads rd for store data and the branch test
    assign id_ra2  = (id_op inside {OP_SW, OP_BEQZ}) ? fd_instr.r_form.rd : fd_instr.r_form.rs2;
    assign id_use1 = !(id_op inside {OP_BEQZ, OP_HALT});
    assign id_use2 = id_op inside {[OP_ADD:OP_XOR], OP_SW, OP_BEQZ};

    // load in execute feeding the instruction in decode
    assign ex_op    = de_instr.r_form.opcode;
    assign ld_rd    = de_instr.r_form.rd;
    assign stall_id = fd_valid && de_valid && ex_op == OP_LW && ld_rd != '0 &&
                      ((id_use1 && fd_instr.r_form.rs1 == ld_rd) ||
                       (id_use2 && id_ra2 == ld_rd));

    core_regfile u_regfile (
        .clk (clk),
        .rst (rst),
        .ra1 (fd_instr.r_form.rs1),
        .ra2 (id_ra2),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2),
        .we  (wb_we),
        .wa  (wb_rd),
        .wd  (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        ex_f1  = fwd(de_instr.r_form.rs1, de_v1);
        ex_f2  = fwd(de_s2, de_v2);
        // size cast keeps the sign of the 6-bit field
        ex_imm = `CPU_DATA_W'(de_instr.i_form.imm);
        alu_a  = (ex_op == OP_BEQZ) ? ex_f2 : ex_f1;
        alu_b  = (ex_op inside {[OP_ADD:OP_XOR]}) ? ex_f2 : ex_imm;
    end

    core_alu u_alu (
        .op   (ex_op),
        .a    (alu_a),
        .b    (alu_b),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // target is pc + 1 + imm, taken branch kills fetch and decode
    assign br_target = de_pc + 1'b1 + `CPU_ADDR_W'(de_instr.i_form.imm);
    assign flush_br  = de_valid && ex_op == OP_BEQZ && alu_zero;

    ////////////////////////////////////////////////////////////
    // memory and write-back
    ////////////////////////////////////////////////////////////

    assign mem_op     = em_instr.r_form.opcode;
    assign dmem_addr  = em_alu[`CPU_ADDR_W-1:0];
    assign dmem_we    = em_valid && mem_op == OP_SW;
    assign dmem_wdata = em_sd;

    assign wb_op    = mw_instr.r_form.opcode;
    assign wb_valid = mw_valid;
    assign wb_pc    = mw_pc;
    assign wb_instr = mw_instr;
    assign wb_rd    = mw_instr.r_form.rd;
    assign wb_we    = mw_valid && writes_rd(wb_op);
    assign wb_data  = mw_data;

    // valid bits, pc and halt state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= '0;
            fd_valid  <= 1'b0;
            de_valid  <= 1'b0;
            em_valid  <= 1'b0;
            mw_valid  <= 1'b0;
            halt_stop <= 1'b0;
            halted    <= 1'b0;
        end else if (advance) begin
            if (flush_br) begin
                pc <= br_target;
            end else if (if_fire) begin
                pc <= pc + 1'b1;
            end
            // decode holds under stall, turns to bubble when fetch is idle
            if (!stall_id) begin
                fd_valid <= if_fire;
            end
            de_valid <= fd_valid && !stall_id && !flush_br;
            em_valid <= de_valid;
            mw_valid <= em_valid;
            if (id_halt && !flush_br) begin
                halt_stop <= 1'b1;
            end
            if (mw_valid && wb_op == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    // payload moves with the valid bits
    always_ff @(posedge clk) begin
        if (advance) begin
            if (!stall_id) begin
                fd_pc    <= pc;
                fd_instr <= imem_data;
            end
            de_pc    <= fd_pc;
            de_instr <= fd_instr;
            de_v1    <= rf_rd1;
            de_v2    <= rf_rd2;
            de_s2    <= id_ra2;
            em_pc    <= de_pc;
            em_instr <= de_instr;
            em_alu   <= alu_y;
            em_sd    <= ex_f2;
            mw_pc    <= em_pc;
            mw_instr <= em_instr;
            mw_data  <= (mem_op == OP_LW) ? dmem_rdata : em_alu;
        end
    end

endmodule

// ==== rtl/pipe_trace_tracker.sv ====
// Stamps of bubble slots read as zero; only slots that reach write-back form records.
`include "cpu_cfg.svh"

module pipe_trace_tracker import isa_pkg::*, trace_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   if_fire,
    input  logic                   advance,
    input  logic                   stall_id,
    input  logic                   flush_br,
    input  logic                   wb_valid,
    input  logic [`CPU_ADDR_W-1:0] wb_pc,
    input  instr_u                 wb_instr,
    input  reg_idx_t               wb_rd,
    input  logic                   wb_we,
    input  logic [`CPU_DATA_W-1:0] wb_data,
    output logic                   rec_valid,
    output trace_seq_t             rec_seq,
    output logic [`CPU_ADDR_W-1:0] rec_pc,
    output instr_u                 rec_instr,
    output reg_idx_t               rec_rd,
    output logic                   rec_we,
    output logic [`CPU_DATA_W-1:0] rec_data,
    output stamp_t                 rec_fetch_stamp,
    output stamp_t                 rec_retire_stamp
);

    // cycle counter and the shadow of each pipeline slot
    stamp_t     cycle;
    stamp_t     d_stamp, e_stamp, m_stamp, w_stamp;
    trace_seq_t seq;

    ////////////////////////////////////////////////////////////
    // shadow pipeline
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle   <= '0;
            seq     <= '0;
            d_stamp <= '0;
            e_stamp <= '0;
            m_stamp <= '0;
            w_stamp <= '0;
        end else begin
            cycle <= cycle + 1'b1;
            if (rec_valid) begin
                seq <= seq + 1'b1;
            end
            // same hold, bubble and kill rules as the core
            if (advance) begin
                if (!stall_id) begin
                    d_stamp <= if_fire ? cycle : '0;
                end
                e_stamp <= (stall_id || flush_br) ? '0 : d_stamp;
                m_stamp <= e_stamp;
                w_stamp <= m_stamp;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // record at write-back
    ////////////////////////////////////////////////////////////

    // a frozen write-back slot retires once, on the cycle it moves
    assign rec_valid        = wb_valid && advance;
    assign rec_seq          = seq;
    assign rec_pc           = wb_pc;
    assign rec_instr        = wb_instr;
    assign rec_rd           = wb_rd;
    assign rec_we           = wb_we;
    assign rec_data         = wb_data;
    assign rec_fetch_stamp  = w_stamp;
    assign rec_retire_stamp = cycle;

endmodule

// ==== rtl/trace_fifo.sv ====
// Writes while full are dropped; the producer is expected to hold off on full.
`include "cpu_cfg.svh"

module trace_fifo import isa_pkg::*, trace_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  trace_seq_t             in_seq,
    input  logic [`CPU_ADDR_W-1:0] in_pc,
    input  instr_u                 in_instr,
    input  reg_idx_t               in_rd,
    input  logic                   in_we,
    input  logic [`CPU_DATA_W-1:0] in_data,
    input  stamp_t                 in_fetch_stamp,
    input  stamp_t                 in_retire_stamp,
    output logic                   full,
    output logic                   trace_valid,
    output trace_seq_t             trace_seq,
    output logic [`CPU_ADDR_W-1:0] trace_pc,
    output instr_u                 trace_instr,
    output reg_idx_t               trace_rd,
    output logic                   trace_we,
    output logic [`CPU_DATA_W-1:0] trace_data,
    output stamp_t                 trace_fetch_stamp,
    output stamp_t                 trace_retire_stamp,
    input  logic                   trace_ready
);

    localparam int PTR_W = $clog2(`TRACE_DEPTH);
    // one record flattened into a single word
    localparam int REC_W = $bits(trace_seq_t) + `CPU_ADDR_W + $bits(instr_u) +
                           $bits(reg_idx_t) + 1 + `CPU_DATA_W + 2 * $bits(stamp_t);

    logic [REC_W-1:0] mem [`TRACE_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             push, pop;

    assign push        = in_valid && !full;
    assign pop         = trace_valid && trace_ready;
    assign full        = count == (PTR_W + 1)'(`TRACE_DEPTH);
    // valid from stored count only, never from ready
    assign trace_valid = count != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at the power-of-two depth
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_seq, in_pc, in_instr, in_rd, in_we, in_data,
                            in_fetch_stamp, in_retire_stamp};
        end
    end

    // head entry stays put until popped
    assign {trace_seq, trace_pc, trace_instr, trace_rd, trace_we, trace_data,
            trace_fetch_stamp, trace_retire_stamp} = mem[rd_ptr];

endmodule

// ==== rtl/pipe_cpu_top.sv ====
// Load the program only while run is low; fetch begins at address 0.
`include "cpu_cfg.svh"

module pipe_cpu_top import isa_pkg::*, trace_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [`CPU_ADDR_W-1:0] prog_addr,
    input  logic [`CPU_DATA_W-1:0] prog_data,
    output logic                   halted,
    output logic                   trace_valid,
    output trace_seq_t             trace_seq,
    output logic [`CPU_ADDR_W-1:0] trace_pc,
    output instr_u                 trace_instr,
    output reg_idx_t               trace_rd,
    output logic                   trace_we,
    output logic [`CPU_DATA_W-1:0] trace_data,
    output stamp_t                 trace_fetch_stamp,
    output stamp_t                 trace_retire_stamp,
    input  logic                   trace_ready
);

    logic [`CPU_ADDR_W-1:0] imem_addr, dmem_addr, wb_pc, rec_pc;
    logic [`CPU_DATA_W-1:0] imem_data, dmem_wdata, dmem_rdata, wb_data, rec_data;
    logic                   dmem_we, if_fire, advance, stall_id, flush_br, full;
    logic                   wb_valid, wb_we, rec_valid, rec_we;
    instr_u                 wb_instr, rec_instr;
    reg_idx_t               wb_rd, rec_rd;
    trace_seq_t             rec_seq;
    stamp_t                 rec_fetch_stamp, rec_retire_stamp;

    // instruction memory, written through the program-load port
    core_mem u_imem (
        .clk(clk), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
        .raddr(imem_addr), .rdata(imem_data)
    );

    // data memory, one address for read and write
    core_mem u_dmem (
        .clk(clk), .we(dmem_we), .waddr(dmem_addr), .wdata(dmem_wdata),
        .raddr(dmem_addr), .rdata(dmem_rdata)
    );

    // a full record queue freezes every stage
    pipe_core u_core (
        .clk(clk), .rst(rst), .run(run), .freeze(full),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata),
        .if_fire(if_fire), .advance(advance), .stall_id(stall_id), .flush_br(flush_br),
        .wb_valid(wb_valid), .wb_pc(wb_pc), .wb_instr(wb_instr), .wb_rd(wb_rd),
        .wb_we(wb_we), .wb_data(wb_data), .halted(halted)
    );

    pipe_trace_tracker u_tracker (
        .clk(clk), .rst(rst),
        .if_fire(if_fire), .advance(advance), .stall_id(stall_id), .flush_br(flush_br),
        .wb_valid(wb_valid), .wb_pc(wb_pc), .wb_instr(wb_instr), .wb_rd(wb_rd),
        .wb_we(wb_we), .wb_data(wb_data),
        .rec_valid(rec_valid), .rec_seq(rec_seq), .rec_pc(rec_pc), .rec_instr(rec_instr),
        .rec_rd(rec_rd), .rec_we(rec_we), .rec_data(rec_data),
        .rec_fetch_stamp(rec_fetch_stamp), .rec_retire_stamp(rec_retire_stamp)
    );

    trace_fifo u_trace_fifo (
        .clk(clk), .rst(rst),
        .in_valid(rec_valid), .in_seq(rec_seq), .in_pc(rec_pc), .in_instr(rec_instr),
        .in_rd(rec_rd), .in_we(rec_we), .in_data(rec_data),
        .in_fetch_stamp(rec_fetch_stamp), .in_retire_stamp(rec_retire_stamp),
        .full(full),
        .trace_valid(trace_valid), .trace_seq(trace_seq), .trace_pc(trace_pc),
        .trace_instr(trace_instr), .trace_rd(trace_rd), .trace_we(trace_we),
        .trace_data(trace_data), .trace_fetch_stamp(trace_fetch_stamp),
        .trace_retire_stamp(trace_retire_stamp), .trace_ready(trace_ready)
    );

endmodule

// ==== verification/tb_pipe_cpu.sv ====
// Data memory must be stored before it is loaded; each run is capped at 40 cycles/record + 200.
`include "cpu_cfg.svh"

module tb_pipe_cpu import isa_pkg::*, trace_pkg::*; ();

    // one expected retirement
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] pc;
        instr_u                 instr;
        reg_idx_t               rd;
        logic                   we;
        logic [`CPU_DATA_W-1:0] data;
    } exp_rec_t;

    logic                   clk, rst, run, prog_we, trace_ready, halted, trace_valid, trace_we;
    logic [`CPU_ADDR_W-1:0] prog_addr, trace_pc;
    logic [`CPU_DATA_W-1:0] prog_data, trace_data;
    trace_seq_t             trace_seq;
    instr_u                 trace_instr;
    reg_idx_t               trace_rd;
    stamp_t                 trace_fetch_stamp, trace_retire_stamp, last_retire;

    // program image and the ISA model state
    instr_u                 prog [`CPU_MEM_DEPTH];
    logic [`CPU_DATA_W-1:0] m_regs [`CPU_NREGS];
    logic [`CPU_DATA_W-1:0] m_mem [`CPU_MEM_DEPTH];
    exp_rec_t               exp_q [$];
    int                     got_count, err_count, total_records, wd_count, wd_limit;
    bit                     wd_armed;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    pipe_cpu_top dut (
        .clk(clk), .rst(rst), .run(run),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .halted(halted), .trace_valid(trace_valid), .trace_seq(trace_seq),
        .trace_pc(trace_pc), .trace_instr(trace_instr), .trace_rd(trace_rd),
        .trace_we(trace_we), .trace_data(trace_data),
        .trace_fetch_stamp(trace_fetch_stamp), .trace_retire_stamp(trace_retire_stamp),
        .trace_ready(trace_ready)
    );

    ////////////////////////////////////////////////////////////
    // instruction encoding and the ISA model
    ////////////////////////////////////////////////////////////

    function automatic instr_u reg_form(opcode_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        instr_u w;
        w.r_form.opcode = op;
        w.r_form.rd     = rd;
        w.r_form.rs1    = rs1;
        w.r_form.rs2    = rs2;
        w.r_form.unused = 3'b000;
        return w;
    endfunction

    function automatic instr_u imm_form(opcode_e op, reg_idx_t rd, reg_idx_t rs1, int imm);
        instr_u w;
        w.i_form.opcode = op;
        w.i_form.rd     = rd;
        w.i_form.rs1    = rs1;
        w.i_form.imm    = imm[5:0];
        return w;
    endfunction

    // executes one instruction in program order, logs its retirement, returns the next pc
    function automatic logic [`CPU_ADDR_W-1:0] isa_step(logic [`CPU_ADDR_W-1:0] pc);
        instr_u                 ins;
        exp_rec_t               r;
        logic [`CPU_DATA_W-1:0] a, b, imm, sum;
        logic [`CPU_ADDR_W-1:0] nxt;
        ins   = prog[pc];
        a     = m_regs[ins.r_form.rs1];
        b     = m_regs[ins.r_form.rs2];
        imm   = {{(`CPU_DATA_W-6){ins.i_form.imm[5]}}, ins.i_form.imm};
        sum   = a + imm;
        nxt   = pc + 1'b1;
        r.pc  = pc;
        r.instr = ins;
        r.rd  = ins.r_form.rd;
        r.we  = 1'b1;
        r.data = '0;
        case (ins.r_form.opcode)
            OP_ADD:  r.data = a + b;
            OP_SUB:  r.data = a - b;
            OP_AND:  r.data = a & b;
            OP_OR:   r.data = a | b;
            OP_XOR:  r.data = a ^ b;
            OP_ADDI: r.data = sum;
            OP_LW:   r.data = m_mem[sum[`CPU_ADDR_W-1:0]];
            default: r.we = 1'b0;
        endcase
        // store data and the branch test both come from rd
        if (ins.r_form.opcode == OP_SW) begin
            m_mem[sum[`CPU_ADDR_W-1:0]] = m_regs[ins.r_form.rd];
        end
        if (ins.r_form.opcode == OP_BEQZ && m_regs[ins.r_form.rd] == '0) begin
            nxt = pc + 1'b1 + imm[`CPU_ADDR_W-1:0];
        end
        if (r.we && r.rd != '0) begin
            m_regs[r.rd] = r.data;
        end
        exp_q.push_back(r);
        return nxt;
    endfunction

    task automatic build_expected();
        logic [`CPU_ADDR_W-1:0] pc;
        int                     steps;
        exp_q.delete();
        for (int i = 0; i < `CPU_NREGS; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            m_mem[i] = '0;
        end
        pc    = '0;
        steps = 0;
        do begin
            pc = isa_step(pc);
            steps++;
        end while (exp_q[$].instr.r_form.opcode != OP_HALT && steps < 500);
    endtask

    // undefined opcode 15 with the address in the low bits
    task automatic clear_program();
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            prog[i] = {4'hF, 6'd0, 6'(i)};
        end
    endtask

    // countdown loop, the back branch tests r0
    task automatic loop_program(input int count);
        clear_program();
        prog[0] = imm_form(OP_ADDI, 1, 0, count);
        prog[1] = imm_form(OP_ADDI, 2, 0, 0);
        prog[2] = imm_form(OP_ADDI, 2, 2, 3);
        prog[3] = imm_form(OP_ADDI, 1, 1, -1);
        prog[4] = imm_form(OP_BEQZ, 1, 0, 1);
        prog[5] = imm_form(OP_BEQZ, 0, 0, -4);
        prog[6] = reg_form(OP_ADD, 3, 2, 1);
        prog[7] = imm_form(OP_HALT, 0, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks and the compare process
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [`CPU_DATA_W-1:0] got,
                              input logic [`CPU_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s record %0d: got %h expected %h", name, got_count, got, exp);
            err_count++;
        end
    endtask

    task automatic check_instr(input instr_u got, input instr_u exp);
        if (got !== exp) begin
            $display("mismatch instr record %0d: got %h expected %h", got_count, got, exp);
            err_count++;
        end
    endtask

    task automatic check_seq(input trace_seq_t got, input trace_seq_t exp);
        if (got !== exp) begin
            $display("mismatch seq: got %h expected %h", got, exp);
            err_count++;
        end
    endtask

    task automatic check_record();
        exp_rec_t e;
        if (got_count >= exp_q.size()) begin
            $display("record with seq %0d came after the last expected retirement", trace_seq);
            err_count++;
        end else begin
            e = exp_q[got_count];
            check_seq(trace_seq, trace_seq_t'(got_count));
            check_word("pc", 16'(trace_pc), 16'(e.pc));
            check_instr(trace_instr, e.instr);
            check_word("rd", 16'(trace_rd), 16'(e.rd));
            check_word("we", 16'(trace_we), 16'(e.we));
            // only written values are defined by the ISA
            if (e.we) begin
                check_word("data", trace_data, e.data);
            end
        end
        if (stamp_t'(trace_retire_stamp - trace_fetch_stamp) < 4) begin
            $display("record %0d retired less than four cycles after fetch", got_count);
            err_count++;
        end
        if (got_count > 0 && trace_retire_stamp <= last_retire) begin
            $display("record %0d retire stamp did not rise", got_count);
            err_count++;
        end
        last_retire = trace_retire_stamp;
        got_count++;
    endtask

    // a record moves on the edge where valid and ready are both high
    always @(posedge clk) begin
        if (trace_valid && trace_ready) begin
            check_record();
        end
    end

    // cycle budget of the running test
    always @(posedge clk) begin
        if (wd_armed) begin
            wd_count++;
        end
    end

    initial begin
        wait (wd_armed && wd_count > wd_limit);
        $display("timeout after %0d cycles without halt and all records", wd_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    task automatic run_program(input int num, input string name, input bit random_ready);
        int hold;
        int errs_before;
        build_expected();
        errs_before = err_count;
        @(negedge clk);
        rst         = 1'b1;
        run         = 1'b0;
        trace_ready = 1'b0;
        repeat (16) @(negedge clk);
        rst       = 1'b0;
        got_count = 0;
        // reset leaves no halt and an empty record queue
        if (halted || trace_valid) begin
            $display("halted or trace_valid still high after reset");
            err_count++;
        end
        // program load while the core sits idle
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            prog_we   = 1'b1;
            prog_addr = `CPU_ADDR_W'(i);
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we  = 1'b0;
        wd_count = 0;
        wd_limit = 40 * exp_q.size() + 200;
        wd_armed = 1'b1;
        run      = 1'b1;
        hold     = 0;
        while (!(halted && got_count >= exp_q.size())) begin
            if (!random_ready) begin
                trace_ready = 1'b1;
            end else if (hold == 0) begin
                // new ready level kept for up to 24 cycles
                trace_ready = 1'($urandom % 2);
                hold        = 1 + $urandom % 24;
            end else begin
                hold--;
            end
            @(negedge clk);
        end
        // quiet window, nothing may follow the halt record
        trace_ready = 1'b1;
        repeat (20) @(negedge clk);
        wd_armed = 1'b0;
        if (!halted) begin
            $display("halted dropped after the halt instruction retired");
            err_count++;
        end
        if (got_count != exp_q.size()) begin
            $display("got %0d records where the model retires %0d", got_count, exp_q.size());
            err_count++;
        end
        total_records += got_count;
        $display("test %0d %s: %0d records, %0d errors", num, name, got_count,
                 err_count - errs_before);
    endtask

    initial begin
        void'($urandom(49294));
        rst           = 1'b1;
        run           = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        trace_ready   = 1'b0;
        got_count     = 0;
        err_count     = 0;
        total_records = 0;
        wd_count      = 0;
        wd_limit      = 0;
        wd_armed      = 1'b0;
        last_retire   = '0;

        // back-to-back dependencies through every register op
        clear_program();
        prog[0] = imm_form(OP_ADDI, 1, 0, 13);
        prog[1] = imm_form(OP_ADDI, 2, 1, -6);
        prog[2] = reg_form(OP_ADD, 3, 1, 2);
        prog[3] = reg_form(OP_SUB, 4, 2, 3);
        prog[4] = reg_form(OP_AND, 5, 4, 3);
        prog[5] = reg_form(OP_OR, 6, 5, 1);
        prog[6] = reg_form(OP_XOR, 7, 6, 4);
        prog[7] = imm_form(OP_HALT, 0, 0, 0);
        run_program(1, "alu forwarding", 1'b0);

        // stores read back, loads used by the very next instruction
        clear_program();
        prog[0] = imm_form(OP_ADDI, 1, 0, 9);
        prog[1] = imm_form(OP_ADDI, 2, 0, 20);
        prog[2] = imm_form(OP_SW, 1, 2, 0);
        prog[3] = imm_form(OP_LW, 3, 2, 0);
        prog[4] = reg_form(OP_ADD, 4, 3, 3);
        prog[5] = imm_form(OP_SW, 4, 2, 1);
        prog[6] = imm_form(OP_LW, 5, 2, 1);
        prog[7] = imm_form(OP_ADDI, 6, 5, -1);
        prog[8] = imm_form(OP_LW, 7, 2, 0);
        prog[9] = imm_form(OP_SW, 7, 2, 2);
        prog[10] = imm_form(OP_LW, 1, 2, 2);
        prog[11] = imm_form(OP_HALT, 0, 0, 0);
        run_program(2, "load store", 1'b0);

        loop_program(4);
        run_program(3, "branch loop", 1'b0);

        loop_program(7);
        run_program(4, "trace back-pressure", 1'b1);

        $display("tests 4, records %0d, errors %0d", total_records, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/trace_pkg.sv
rtl/core_mem.sv
rtl/core_regfile.sv
rtl/core_alu.sv
rtl/pipe_core.sv
rtl/pipe_trace_tracker.sv
rtl/trace_fifo.sv
rtl/pipe_cpu_top.sv
verification/tb_pipe_cpu.sv

// ==== Makefile ====
# Verilator flow for the pipelined core and its trace unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module pipe_cpu_top

obj_dir/tb_sim: flist.f rtl/*.sv rtl/*.svh verification/*.sv
	verilator --binary --timing -f flist.f --top-module tb_pipe_cpu -o tb_sim

# pass only when the pass line shows up in the simulation output
sim: obj_dir/tb_sim
	out="$$(./obj_dir/tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
